/* design/histoCfgPkg.sv */
package histoCfgPkg;

    // input sample codes
    localparam int codeWidth = 8;
    // top code bits select the coarse bin
    localparam int coarseWidth = 5;
    // 8 codes per coarse bin
    localparam int coarseShift = codeWidth - coarseWidth;
    // fine window is 32 codes wide
    localparam int fineWidth = 5;
    localparam int binNum = 1 << fineWidth;

    // fixed arrival order: acquisition, pixel, sample
    localparam int pixelNum = 4;
    localparam int pixelWidth = 2;
    localparam int samplesPerPixel = 4;
    localparam int sampleCntWidth = $clog2(samplesPerPixel);
    localparam int acqNum = 3;
    localparam int acqCntWidth = $clog2(acqNum);

    // at most 12 hits per bin in one pass
    localparam int countWidth = 8;

    // ingress buffer depth equals the credits at reset
    localparam int creditDepth = 4;
    localparam int ptrWidth = $clog2(creditDepth);

    // window placement around the coarse peak
    localparam int binCentre = 1 << (coarseShift - 1);
    localparam int windowLead = binNum / 2;
    localparam int windowLowMax = 224;

    // phase sequencing
    localparam int drainCycles = 2;
    localparam int stepWidth = 3;

endpackage

/* design/histoTypesPkg.sv */
package histoTypesPkg;

    import histoCfgPkg::*;

    // one sweep walks through these in order
    typedef enum logic [2:0] {
        coarsePass,
        windowCalc,
        finePass,
        reportOut,
        clearMem
    } sweepPhase;

    // per-pixel sweep result
    typedef struct packed {
        logic [pixelWidth-1:0] pixel;
        logic [coarseWidth-1:0] coarse;
        // fine peak code
        logic [codeWidth-1:0] fine;
        logic [countWidth-1:0] count;
    } peakResult;

endpackage

/* design/binUpdateIf.sv */
`timescale 1ns/1ps

interface binUpdateIf import histoCfgPkg::*; ();

    // bin increment request
    logic updValid;
    logic [pixelWidth-1:0] updPixel;
    logic [fineWidth-1:0] updBin;
    // drops every valid bit and every stored peak
    logic flashClear;

    // count after the increment
    logic newValid;
    logic [pixelWidth-1:0] newPixel;
    logic [fineWidth-1:0] newBin;
    logic [countWidth-1:0] newCount;

    modport ctrl (output updValid, updPixel, updBin, flashClear);
    modport mem (input updValid, updPixel, updBin, flashClear,
                 output newValid, newPixel, newBin, newCount);
    modport tracker (input newValid, newPixel, newBin, newCount, flashClear);

endinterface

/* design/peakReportIf.sv */
`timescale 1ns/1ps

interface peakReportIf import histoCfgPkg::*; ();

    // dump request, passSel high for the fine pass
    logic dumpReq;
    logic [pixelWidth-1:0] dumpPixel;
    logic passSel;

    // stored peak of the dumped pixel
    logic peakValid;
    logic [pixelWidth-1:0] peakPixel;
    logic [fineWidth-1:0] peakBin;
    logic [countWidth-1:0] peakCount;

    modport ctrl (output dumpReq, dumpPixel, passSel);
    modport tracker (input dumpReq, dumpPixel, output peakValid, peakPixel, peakBin, peakCount);
    modport window (input passSel, peakValid, peakPixel, peakBin, peakCount);

endinterface

/* design/creditIngress.sv */
`timescale 1ns/1ps

module creditIngress import histoCfgPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic sampleValid,
    input  logic [codeWidth-1:0] sampleCode,
    input  logic fifoPop,
    output logic fifoValid,
    output logic [codeWidth-1:0] fifoCode,
    output logic creditReturn
);

    logic [codeWidth-1:0] fifoMem [creditDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    // one extra bit so a full buffer is visible
    logic [ptrWidth:0] fillCnt;

    assign fifoValid = (fillCnt != '0);
    // head entry shows without a read cycle
    assign fifoCode = fifoMem[rdPtr];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCnt <= '0;
            creditReturn <= 1'b0;
        end else begin
            // credit goes back the cycle after the pop
            creditReturn <= fifoPop;
            if (sampleValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (fifoPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({sampleValid, fifoPop})
                2'b10: fillCnt <= fillCnt + 1'b1;
                2'b01: fillCnt <= fillCnt - 1'b1;
                default: fillCnt <= fillCnt;
            endcase
        end
    end

    // sender holds a credit for every push, so no full check
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            fifoMem[wrPtr] <= sampleCode;
        end
    end

endmodule

/* design/sweepControl.sv */
`timescale 1ns/1ps

module sweepControl import histoCfgPkg::*, histoTypesPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic fifoValid,
    input  logic [codeWidth-1:0] fifoCode,
    output logic fifoPop,
    binUpdateIf.ctrl binUpd,
    peakReportIf.ctrl peakRep,
    input  logic inWindow,
    input  logic [fineWidth-1:0] fineBin,
    output logic [pixelWidth-1:0] samplePixel,
    output logic finePhase,
    output logic resultValid,
    output logic [pixelWidth-1:0] resultPixel
);

    sweepPhase phase;
    // drain wait in the passes, dump index otherwise
    logic [stepWidth-1:0] stepCnt;
    logic [sampleCntWidth-1:0] sampCnt;
    logic [pixelWidth-1:0] pixCnt;
    logic [acqCntWidth-1:0] acqCnt;
    // last sample of the pass already popped
    logic passEnd;
    logic inPass;
    logic lastSample;
    logic dumpDone;
    logic fineDumpD1;
    logic [pixelWidth-1:0] dumpPixelD1;

    assign inPass = (phase == coarsePass) || (phase == finePass);
    assign finePhase = (phase == finePass);
    assign samplePixel = pixCnt;
    assign fifoPop = inPass && !passEnd && fifoValid;
    assign lastSample = (sampCnt == sampleCntWidth'(samplesPerPixel - 1))
        && (pixCnt == pixelWidth'(pixelNum - 1))
        && (acqCnt == acqCntWidth'(acqNum - 1));

    // one pixel per cycle, then a spare cycle for the last peak to land
    assign dumpDone = (stepCnt == stepWidth'(pixelNum));
    assign peakRep.dumpReq = ((phase == windowCalc) || (phase == reportOut)) && !dumpDone;
    assign peakRep.dumpPixel = stepCnt[pixelWidth-1:0];
    assign peakRep.passSel = (phase == reportOut);
    // bins and peaks start empty for the fine pass and for the next sweep
    assign binUpd.flashClear = ((phase == windowCalc) && dumpDone) || (phase == clearMem);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            phase <= coarsePass;
            stepCnt <= '0;
            passEnd <= 1'b0;
        end else begin
            case (phase)
                coarsePass, finePass: begin
                    if (fifoPop && lastSample) begin
                        passEnd <= 1'b1;
                    end else if (passEnd) begin
                        // accumulator then tracker must settle
                        if (stepCnt == stepWidth'(drainCycles - 1)) begin
                            stepCnt <= '0;
                            passEnd <= 1'b0;
                            phase <= (phase == coarsePass) ? windowCalc : reportOut;
                        end else begin
                            stepCnt <= stepCnt + 1'b1;
                        end
                    end
                end
                windowCalc, reportOut: begin
                    if (dumpDone) begin
                        stepCnt <= '0;
                        phase <= (phase == windowCalc) ? finePass : clearMem;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                // clearMem lasts a single cycle
                default: phase <= coarsePass;
            endcase
        end
    end

    // sample, pixel and acquisition counters
    // dropped fine samples still count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampCnt <= '0;
            pixCnt <= '0;
            acqCnt <= '0;
        end else if (fifoPop) begin
            if (sampCnt == sampleCntWidth'(samplesPerPixel - 1)) begin
                sampCnt <= '0;
                if (pixCnt == pixelWidth'(pixelNum - 1)) begin
                    pixCnt <= '0;
                    if (acqCnt == acqCntWidth'(acqNum - 1)) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixCnt <= pixCnt + 1'b1;
                end
            end else begin
                sampCnt <= sampCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binUpd.updValid <= 1'b0;
            fineDumpD1 <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            // out-of-window fine samples are popped and dropped
            binUpd.updValid <= fifoPop && (!finePhase || inWindow);
            // tracker answers after one cycle, window block after two
            fineDumpD1 <= peakRep.dumpReq && peakRep.passSel;
            resultValid <= fineDumpD1;
        end
    end

    always_ff @(posedge clk) begin
        binUpd.updPixel <= pixCnt;
        // coarse bin is the top code bits
        binUpd.updBin <= finePhase ? fineBin : fifoCode[codeWidth-1 -: coarseWidth];
        dumpPixelD1 <= peakRep.dumpPixel;
        resultPixel <= dumpPixelD1;
    end

endmodule

/* design/binAccumulator.sv */
`timescale 1ns/1ps

module binAccumulator import histoCfgPkg::*; (
    input logic clk,
    input logic combin_res,
    binUpdateIf.mem binUpd
);

    // pixel-major count memory
    logic [countWidth-1:0] countMem [pixelNum * binNum];
    // bin reads as zero while its bit is clear
    logic [pixelNum*binNum-1:0] binValid;
    logic [pixelWidth+fineWidth-1:0] updAddr;
    logic [pixelWidth+fineWidth-1:0] rdAddr;
    logic rdValid;
    logic [countWidth-1:0] rdBase;
    logic sameBin;

    assign updAddr = {binUpd.updPixel, binUpd.updBin};
    assign rdAddr = {binUpd.newPixel, binUpd.newBin};
    // previous update writes this same bin at the coming edge
    assign sameBin = rdValid && (rdAddr == updAddr);

    assign binUpd.newValid = rdValid;
    assign binUpd.newCount = rdBase + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rdValid <= 1'b0;
            binValid <= '0;
        end else begin
            rdValid <= binUpd.updValid;
            if (binUpd.flashClear) begin
                binValid <= '0;
            end else if (rdValid) begin
                binValid[rdAddr] <= 1'b1;
            end
        end
    end

    // read stage
    always_ff @(posedge clk) begin
        if (binUpd.updValid) begin
            binUpd.newPixel <= binUpd.updPixel;
            binUpd.newBin <= binUpd.updBin;
            if (sameBin) begin
                // forward the count still in flight
                rdBase <= binUpd.newCount;
            end else if (binValid[updAddr]) begin
                rdBase <= countMem[updAddr];
            end else begin
                rdBase <= '0;
            end
        end
    end

    // write back the incremented count
    always_ff @(posedge clk) begin
        if (rdValid) begin
            countMem[rdAddr] <= binUpd.newCount;
        end
    end

endmodule

/* design/peakTracker.sv */
`timescale 1ns/1ps

module peakTracker import histoCfgPkg::*; (
    input logic clk,
    input logic combin_res,
    binUpdateIf.tracker binUpd,
    peakReportIf.tracker peakRep
);

    // running max per pixel
    logic [countWidth-1:0] maxCount [pixelNum];
    logic [fineWidth-1:0] maxBin [pixelNum];
    logic newPeak;

    // strictly greater, so the first bin to reach the max keeps it
    assign newPeak = binUpd.newValid && (binUpd.newCount > maxCount[binUpd.newPixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakRep.peakValid <= 1'b0;
            for (int i = 0; i < pixelNum; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
        end else begin
            peakRep.peakValid <= peakRep.dumpReq;
            if (binUpd.flashClear) begin
                // also hit at the coarse to fine switch
                for (int i = 0; i < pixelNum; i++) begin
                    maxCount[i] <= '0;
                    maxBin[i] <= '0;
                end
            end else if (newPeak) begin
                maxCount[binUpd.newPixel] <= binUpd.newCount;
                maxBin[binUpd.newPixel] <= binUpd.newBin;
            end
        end
    end

    // dump answer
    always_ff @(posedge clk) begin
        if (peakRep.dumpReq) begin
            peakRep.peakPixel <= peakRep.dumpPixel;
            peakRep.peakBin <= maxBin[peakRep.dumpPixel];
            peakRep.peakCount <= maxCount[peakRep.dumpPixel];
        end
    end

endmodule

/* design/windowCalc.sv */
`timescale 1ns/1ps

module windowCalc import histoCfgPkg::*, histoTypesPkg::*; (
    input  logic clk,
    input  logic combin_res,
    peakReportIf.window peakRep,
    input  logic [codeWidth-1:0] sampleCode,
    input  logic [pixelWidth-1:0] samplePixel,
    output logic inWindow,
    output logic [fineWidth-1:0] fineBin,
    output logic [coarseWidth-1:0] resultCoarse,
    output logic [codeWidth-1:0] resultFine,
    output logic [countWidth-1:0] resultCount
);

    logic [codeWidth-1:0] windowLow [pixelNum];
    logic [coarseWidth-1:0] coarseLatch [pixelNum];
    logic [codeWidth-1:0] centreCode;
    logic [codeWidth-1:0] lowNext;
    logic [codeWidth-1:0] sampleLow;
    logic [codeWidth-1:0] offset;
    // fine field holds the window offset until the low is added
    peakResult finePeak;

    // middle code of the coarse peak bin
    assign centreCode = (codeWidth'(peakRep.peakBin) << coarseShift) + codeWidth'(binCentre);

    // window clamped at both ends of the code range
    always_comb begin
        if (centreCode < codeWidth'(windowLead)) begin
            lowNext = '0;
        end else if (centreCode - codeWidth'(windowLead) > codeWidth'(windowLowMax)) begin
            lowNext = codeWidth'(windowLowMax);
        end else begin
            lowNext = centreCode - codeWidth'(windowLead);
        end
    end

    // coarse to fine mapping of the sample at the FIFO head
    assign sampleLow = windowLow[samplePixel];
    assign offset = sampleCode - sampleLow;
    assign inWindow = (sampleCode >= sampleLow) && (offset < codeWidth'(binNum));
    assign fineBin = offset[fineWidth-1:0];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < pixelNum; i++) begin
                windowLow[i] <= '0;
                coarseLatch[i] <= '0;
            end
        end else if (peakRep.peakValid && !peakRep.passSel) begin
            windowLow[peakRep.peakPixel] <= lowNext;
            coarseLatch[peakRep.peakPixel] <= peakRep.peakBin;
        end
    end

    // fine dump result
    always_ff @(posedge clk) begin
        if (peakRep.peakValid && peakRep.passSel) begin
            finePeak.pixel <= peakRep.peakPixel;
            finePeak.coarse <= coarseLatch[peakRep.peakPixel];
            finePeak.fine <= codeWidth'(peakRep.peakBin);
            finePeak.count <= peakRep.peakCount;
        end
    end

    assign resultCoarse = finePeak.coarse;
    assign resultFine = windowLow[finePeak.pixel] + finePeak.fine;
    assign resultCount = finePeak.count;

endmodule

/* design/histoTop.sv */
`timescale 1ns/1ps

module histoTop import histoCfgPkg::*, histoTypesPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic sampleValid,
    input  logic [codeWidth-1:0] sampleCode,
    output logic creditReturn,
    output logic resultValid,
    output logic [pixelWidth-1:0] resultPixel,
    output logic [coarseWidth-1:0] resultCoarse,
    output logic [codeWidth-1:0] resultFine,
    output logic [countWidth-1:0] resultCount,
    output logic finePhase
);

    // ingress to control
    logic fifoValid;
    logic [codeWidth-1:0] fifoCode;
    logic fifoPop;
    // window mapping of the head sample
    logic inWindow;
    logic [fineWidth-1:0] fineBin;
    logic [pixelWidth-1:0] samplePixel;
    // report fields from control and window block
    peakResult result;

    binUpdateIf binUpd ();
    peakReportIf peakRep ();

    creditIngress ingress (
        .clk(clk), .combin_res(combin_res),
        .sampleValid(sampleValid), .sampleCode(sampleCode),
        .fifoPop(fifoPop), .fifoValid(fifoValid), .fifoCode(fifoCode),
        .creditReturn(creditReturn)
    );

    sweepControl control (
        .clk(clk), .combin_res(combin_res),
        .fifoValid(fifoValid), .fifoCode(fifoCode), .fifoPop(fifoPop),
        .binUpd(binUpd.ctrl), .peakRep(peakRep.ctrl),
        .inWindow(inWindow), .fineBin(fineBin), .samplePixel(samplePixel),
        .finePhase(finePhase), .resultValid(resultValid), .resultPixel(result.pixel)
    );

    binAccumulator accum (.clk(clk), .combin_res(combin_res), .binUpd(binUpd.mem));

    peakTracker tracker (
        .clk(clk), .combin_res(combin_res),
        .binUpd(binUpd.tracker), .peakRep(peakRep.tracker)
    );

    windowCalc window (
        .clk(clk), .combin_res(combin_res), .peakRep(peakRep.window),
        .sampleCode(fifoCode), .samplePixel(samplePixel),
        .inWindow(inWindow), .fineBin(fineBin),
        .resultCoarse(result.coarse), .resultFine(result.fine), .resultCount(result.count)
    );

    assign resultPixel = result.pixel;
    assign resultCoarse = result.coarse;
    assign resultFine = result.fine;
    assign resultCount = result.count;

endmodule

/* testbench/histoChecker.sv */
`timescale 1ns/1ps

module histoChecker import histoCfgPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic sampleValid,
    input  logic [codeWidth-1:0] sampleCode,
    input  logic creditReturn,
    input  logic resultValid,
    input  logic [pixelWidth-1:0] resultPixel,
    input  logic [coarseWidth-1:0] resultCoarse,
    input  logic [codeWidth-1:0] resultFine,
    input  logic [countWidth-1:0] resultCount,
    input  logic finePhase,
    input  logic endOfRun,
    output int valueErrors,
    output int flowErrors,
    output int resultsSeen
);

    // samples in one pass, one sweep is two passes
    localparam int passLen = acqNum * pixelNum * samplesPerPixel;
    localparam int codesPerBin = 1 << coarseShift;

    // model histogram and running max of the pass in progress
    int hist [pixelNum][binNum];
    int peakCount [pixelNum];
    int peakBin [pixelNum];
    // coarse pass outcome, used by the fine pass
    int lowCode [pixelNum];
    int coarseBin [pixelNum];
    int sampleIdx;
    int checkedCnt;
    // expected results of finished sweeps, oldest first
    int expCoarse [$];
    int expFine [$];
    int expCount [$];
    int sentCnt;
    int returnedCnt;
    bit resultValidD1;
    bit endChecked;
    // fine pass tracking, pops are seen through the credit pulses
    bit finePhaseD1;
    int fineStarts;

    // 32-code window around the middle of the coarse peak bin
    function automatic int windowLowOf(input int bin);
        int low;
        low = bin * codesPerBin + codesPerBin / 2 - binNum / 2;
        // clamp at both ends of the code range
        if (low < 0) begin
            low = 0;
        end else if (low > windowLowMax) begin
            low = windowLowMax;
        end
        return low;
    endfunction

    task automatic clearModel();
        for (int p = 0; p < pixelNum; p++) begin
            peakCount[p] = 0;
            peakBin[p] = 0;
            for (int b = 0; b < binNum; b++) begin
                hist[p][b] = 0;
            end
        end
    endtask

    task automatic checkField(input string name, input int expected, input int actual);
        if (expected != actual) begin
            valueErrors++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // model fed by accepted samples, then result comparison
    always @(posedge clk) begin : modelFeed
        int pix;
        int bin;
        bit hit;
        string tag;
        if (combin_res && sampleValid) begin
            // arrival order: acquisition, pixel, sample
            pix = ((sampleIdx % passLen) / samplesPerPixel) % pixelNum;
            hit = 1'b1;
            if (sampleIdx < passLen) begin
                bin = int'(sampleCode) / codesPerBin;
            end else begin
                // fine bin is the offset into the window
                bin = int'(sampleCode) - lowCode[pix];
                hit = (bin >= 0) && (bin < binNum);
            end
            if (hit) begin
                hist[pix][bin]++;
                // strictly greater keeps the first bin to reach the max
                if (hist[pix][bin] > peakCount[pix]) begin
                    peakCount[pix] = hist[pix][bin];
                    peakBin[pix] = bin;
                end
            end
            sampleIdx++;
            if (sampleIdx == passLen) begin
                for (int p = 0; p < pixelNum; p++) begin
                    coarseBin[p] = peakBin[p];
                    lowCode[p] = windowLowOf(peakBin[p]);
                end
                clearModel();
            end else if (sampleIdx == 2 * passLen) begin
                for (int p = 0; p < pixelNum; p++) begin
                    expCoarse.push_back(coarseBin[p]);
                    expFine.push_back(lowCode[p] + peakBin[p]);
                    expCount.push_back(peakCount[p]);
                end
                clearModel();
                sampleIdx = 0;
            end
        end
        if (combin_res && resultValid && expCoarse.size() != 0) begin
            tag = $sformatf("sweep%0d pixel%0d", checkedCnt / pixelNum, checkedCnt % pixelNum);
            checkField({tag, " coarse"}, expCoarse.pop_front(), resultCoarse);
            checkField({tag, " fine"}, expFine.pop_front(), resultFine);
            checkField({tag, " count"}, expCount.pop_front(), resultCount);
            checkedCnt++;
        end
    end

    // credit balance, result order and end-of-run counts
    always @(posedge clk) begin
        if (combin_res) begin
            if (creditReturn) begin
                returnedCnt++;
                if (returnedCnt > sentCnt) begin
                    flowErrors++;
                    $display("credit returned with no sample outstanding");
                end
            end
            if (sampleValid) begin
                sentCnt++;
            end
            if (resultValid) begin
                if (int'(resultPixel) != resultsSeen % pixelNum) begin
                    flowErrors++;
                    $display("ERR result order pixel expected %0d actual %0d",
                             resultsSeen % pixelNum, resultPixel);
                end
                // one burst of pixelNum cycles per sweep
                if (resultPixel != '0 && !resultValidD1) begin
                    flowErrors++;
                    $display("result burst broken before pixel %0d", resultPixel);
                end
                resultsSeen++;
                if (resultsSeen > (sentCnt / (2 * passLen)) * pixelNum) begin
                    flowErrors++;
                    $display("result appeared before its sweep was fully sent");
                end
            end
            resultValidD1 = resultValid;
            // fine pass covers exactly the second half of each sweep's pops
            if (finePhase && !finePhaseD1) begin
                if (returnedCnt != fineStarts * 2 * passLen + passLen) begin
                    flowErrors++;
                    $display("ERR fine pass start pops expected %0d actual %0d",
                             fineStarts * 2 * passLen + passLen, returnedCnt);
                end
                fineStarts++;
            end
            if (!finePhase && finePhaseD1 && returnedCnt != fineStarts * 2 * passLen) begin
                flowErrors++;
                $display("ERR fine pass end pops expected %0d actual %0d",
                         fineStarts * 2 * passLen, returnedCnt);
            end
            if (finePhase && resultValid) begin
                flowErrors++;
                $display("fine pass flag still high during result output");
            end
            finePhaseD1 = finePhase;
            if (endOfRun && !endChecked) begin
                endChecked = 1'b1;
                if (returnedCnt != sentCnt) begin
                    flowErrors++;
                    $display("%0d samples sent but %0d credits returned", sentCnt, returnedCnt);
                end
                if (resultsSeen != (sentCnt / (2 * passLen)) * pixelNum) begin
                    flowErrors++;
                    $display("wrong number of results, %0d seen", resultsSeen);
                end
                if (fineStarts != sentCnt / (2 * passLen) || finePhase) begin
                    flowErrors++;
                    $display("%0d fine passes run, fine flag %0b at the end",
                             fineStarts, finePhase);
                end
            end
        end
    end

endmodule

/* testbench/histoTb.sv */
`timescale 1ns/1ps

module histoTb import histoCfgPkg::*; ();

    localparam int clkPeriod = 20;
    localparam int driveDelay = 2;
    localparam int sweepNum = 6;
    // idle cycles between samples are 0 to maxGap
    localparam int maxGap = 3;
    localparam int watchdogCycles =
        sweepNum * pixelNum * acqNum * samplesPerPixel * (maxGap + 2) + 200 * sweepNum;

    logic clk;
    logic combin_res;
    logic sampleValid;
    logic [codeWidth-1:0] sampleCode;
    logic creditReturn;
    logic resultValid;
    logic [pixelWidth-1:0] resultPixel;
    logic [coarseWidth-1:0] resultCoarse;
    logic [codeWidth-1:0] resultFine;
    logic [countWidth-1:0] resultCount;
    logic finePhase;
    logic endOfRun;
    int valueErrors;
    int flowErrors;
    int resultsSeen;
    // sender side credit count
    int credits;
    logic [31:0] rngState = 32'hd6a1da6e;

    histoTop dut (
        .clk(clk), .combin_res(combin_res),
        .sampleValid(sampleValid), .sampleCode(sampleCode),
        .creditReturn(creditReturn), .resultValid(resultValid),
        .resultPixel(resultPixel), .resultCoarse(resultCoarse),
        .resultFine(resultFine), .resultCount(resultCount), .finePhase(finePhase)
    );

    histoChecker scoreboard (
        .clk(clk), .combin_res(combin_res),
        .sampleValid(sampleValid), .sampleCode(sampleCode),
        .creditReturn(creditReturn), .resultValid(resultValid),
        .resultPixel(resultPixel), .resultCoarse(resultCoarse),
        .resultFine(resultFine), .resultCount(resultCount),
        .finePhase(finePhase), .endOfRun(endOfRun),
        .valueErrors(valueErrors), .flowErrors(flowErrors), .resultsSeen(resultsSeen)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // spend one per accepted sample, regain one per return pulse
    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            credits <= creditDepth;
        end else begin
            credits <= credits + (creditReturn ? 1 : 0) - (sampleValid ? 1 : 0);
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [codeWidth-1:0] pickCode(input int centre);
        logic [31:0] r;
        int code;
        r = nextRandom();
        // one hit in eight lands anywhere, mostly outside the window
        if (r[2:0] == 3'd0) begin
            code = int'(r[15:8]);
        end else begin
            code = centre + int'(r[11:8]) % 9 - 4;
        end
        if (code < 0) begin
            code = 0;
        end else if (code > 255) begin
            code = 255;
        end
        return codeWidth'(code);
    endfunction

    task automatic sendSample(input logic [codeWidth-1:0] code);
        int gap;
        // stall until a credit is back
        while (credits == 0) begin
            @(posedge clk);
            #driveDelay;
        end
        sampleValid = 1'b1;
        sampleCode = code;
        @(posedge clk);
        #driveDelay;
        sampleValid = 1'b0;
        gap = int'(nextRandom() % (maxGap + 1));
        repeat (gap) begin
            @(posedge clk);
            #driveDelay;
        end
    endtask

    task automatic runSweep(input int sweep);
        int centre [pixelNum];
        for (int p = 0; p < pixelNum; p++) begin
            // sweep 1 hugs code 0, sweep 3 hugs code 255
            if (sweep == 1) begin
                centre[p] = 1 + 4 * p;
            end else if (sweep == 3) begin
                centre[p] = 254 - 4 * p;
            end else begin
                centre[p] = int'(nextRandom() % 256);
            end
        end
        // coarse then fine pass, same pixel order in both
        for (int rep = 0; rep < 2 * acqNum; rep++) begin
            for (int p = 0; p < pixelNum; p++) begin
                repeat (samplesPerPixel) sendSample(pickCode(centre[p]));
            end
        end
    endtask

    initial begin
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sampleCode = '0;
        endOfRun = 1'b0;
        repeat (3) @(posedge clk);
        #driveDelay;
        combin_res = 1'b1;
        for (int s = 0; s < sweepNum; s++) begin
            runSweep(s);
        end
        wait (resultsSeen == sweepNum * pixelNum);
        repeat (4) @(posedge clk);
        endOfRun = 1'b1;
        repeat (2) @(posedge clk);
        $display("value errors %0d, flow errors %0d", valueErrors, flowErrors);
        if (valueErrors + flowErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("timeout after %0d cycles, %0d results seen", watchdogCycles, resultsSeen);
        $display("Errors found");
        $finish;
    end

endmodule

/* list.f */
design/histoCfgPkg.sv
design/histoTypesPkg.sv
design/binUpdateIf.sv
design/peakReportIf.sv
design/creditIngress.sv
design/sweepControl.sv
design/binAccumulator.sv
design/peakTracker.sv
design/windowCalc.sv
design/histoTop.sv
testbench/histoChecker.sv
testbench/histoTb.sv
